// File: logic/exec_pkg.sv
package exec_pkg;

	// physical register file
	localparam int WIDTH_PRD = 7;
	localparam int NUM_PRD = 1 << WIDTH_PRD;

	localparam int WIDTH_DATA = 32;

	// branch tags and masks, one mask bit per tag
	localparam int WIDTH_BRT = 3;
	localparam int WIDTH_BRM = 1 << WIDTH_BRT;

	// lane 0 is alu plus branch, lane 1 plain alu
	localparam int NUM_LANES = 2;

	typedef enum logic [3:0] {
		UOP_ADD  = 4'd0,
		UOP_SUB  = 4'd1,
		UOP_AND  = 4'd2,
		UOP_OR   = 4'd3,
		UOP_XOR  = 4'd4,
		// shift amount is op2[4:0]
		UOP_SLL  = 4'd5,
		UOP_SRL  = 4'd6,
		UOP_SLT  = 4'd7,
		// op1 + imm
		UOP_ADDI = 4'd8,
		// signed compares for blt/bge
		UOP_BEQ  = 4'd9,
		UOP_BNE  = 4'd10,
		UOP_BLT  = 4'd11,
		UOP_BGE  = 4'd12
	} uop_e;

	function automatic logic is_branch(uop_e uop);
		return uop inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE};
	endfunction

	// micro-op depends on a branch being squashed
	function automatic logic killed(
		logic [WIDTH_BRM-1:0] brmask,
		logic [WIDTH_BRM-1:0] kill_mask
	);
		return |(brmask & kill_mask);
	endfunction

endpackage

// File: logic/prf_regfile.sv
`timescale 1ns/100ps

module prf_regfile (
	input  logic                             i_clk,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_raddr [2*exec_pkg::NUM_LANES],
	input  logic                             i_we    [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_waddr [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_wdata [exec_pkg::NUM_LANES],
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_rdata [2*exec_pkg::NUM_LANES]
);

	logic [exec_pkg::WIDTH_DATA-1:0] mem [exec_pkg::NUM_PRD];

	// one write port per lane
	always_ff @(posedge i_clk) begin
		for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
			if (i_we[l])
				mem[i_waddr[l]] <= i_wdata[l];
		end
	end

	// p0 is hardwired zero
	always_comb begin
		for (int r = 0; r < 2*exec_pkg::NUM_LANES; r++) begin
			if (i_raddr[r] == '0)
				o_rdata[r] = '0;
			else
				o_rdata[r] = mem[i_raddr[r]];
		end
	end

	genvar a, b;
	generate
		for (a = 0; a < exec_pkg::NUM_LANES; a++) begin : g_wr_chk
			for (b = a + 1; b < exec_pkg::NUM_LANES; b++) begin : g_pair
				// rename hands out each prd once while in flight
				assert property (@(posedge i_clk)
					!(i_we[a] && i_we[b] && (i_waddr[a] == i_waddr[b])))
				else
					$error("prf: lanes %0d and %0d write p%0d together",
						a, b, i_waddr[a]);
			end
		end
	endgenerate

endmodule

// File: logic/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_prs     [2*exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_rf_data [2*exec_pkg::NUM_LANES],
	input  logic                             i_ex_val  [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_ex_prd  [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_ex_data [exec_pkg::NUM_LANES],
	input  logic                             i_wb_val  [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_wb_prd  [exec_pkg::NUM_LANES],
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_wb_data [exec_pkg::NUM_LANES],
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_op      [2*exec_pkg::NUM_LANES]
);

	// hit flags per source and per lane
	logic [exec_pkg::NUM_LANES-1:0] ex_hit [2*exec_pkg::NUM_LANES];
	logic [exec_pkg::NUM_LANES-1:0] wb_hit [2*exec_pkg::NUM_LANES];

	always_comb begin
		for (int s = 0; s < 2*exec_pkg::NUM_LANES; s++) begin
			for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
				ex_hit[s][l] = i_ex_val[l] && (i_ex_prd[l] == i_prs[s]);
				wb_hit[s][l] = i_wb_val[l] && (i_wb_prd[l] == i_prs[s]);
			end
		end
	end

	// source layout is {prs1, prs2} per lane, lane 0 first
	always_comb begin
		for (int s = 0; s < 2*exec_pkg::NUM_LANES; s++) begin
			o_op[s] = i_rf_data[s];

			// writeback is older than execute, so let execute override
			for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
				if (wb_hit[s][l])
					o_op[s] = i_wb_data[l];
			end
			for (int l = 0; l < exec_pkg::NUM_LANES; l++) begin
				if (ex_hit[s][l])
					o_op[s] = i_ex_data[l];
			end

			// p0 never forwards
			if (i_prs[s] == '0)
				o_op[s] = '0;
		end
	end

endmodule

// File: logic/int_alu.sv
`timescale 1ns/100ps

module int_alu (
	input  exec_pkg::uop_e                   i_uop,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op1,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op2,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_imm,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_result
);

	logic [4:0] shamt;
	logic       lt;

	assign shamt = i_op2[4:0];
	assign lt = $signed(i_op1) < $signed(i_op2);

	always_comb begin
		case (i_uop)
			exec_pkg::UOP_ADD:
				o_result = i_op1 + i_op2;
			exec_pkg::UOP_SUB:
				o_result = i_op1 - i_op2;
			exec_pkg::UOP_AND:
				o_result = i_op1 & i_op2;
			exec_pkg::UOP_OR:
				o_result = i_op1 | i_op2;
			exec_pkg::UOP_XOR:
				o_result = i_op1 ^ i_op2;
			exec_pkg::UOP_SLL:
				o_result = i_op1 << shamt;
			exec_pkg::UOP_SRL:
				o_result = i_op1 >> shamt;
			exec_pkg::UOP_SLT:
				o_result = {{(exec_pkg::WIDTH_DATA-1){1'b0}}, lt};
			exec_pkg::UOP_ADDI:
				o_result = i_op1 + i_imm;
			// branches resolve in branch_unit
			default:
				o_result = '0;
		endcase
	end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_val,
	input  exec_pkg::uop_e                   i_uop,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op1,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op2,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_pc,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_imm,
	input  logic [exec_pkg::WIDTH_BRT-1:0]   i_brtag,
	output logic                             o_taken,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_target,
	output logic [exec_pkg::WIDTH_BRM-1:0]   o_kill_now,
	output logic [exec_pkg::WIDTH_BRM-1:0]   o_kill_mask
);

	logic                           cond;
	logic [exec_pkg::WIDTH_BRM-1:0] kill_prev;

	always_comb begin
		case (i_uop)
			exec_pkg::UOP_BEQ:
				cond = i_op1 == i_op2;
			exec_pkg::UOP_BNE:
				cond = i_op1 != i_op2;
			exec_pkg::UOP_BLT:
				cond = $signed(i_op1) < $signed(i_op2);
			exec_pkg::UOP_BGE:
				cond = $signed(i_op1) >= $signed(i_op2);
			default:
				cond = 1'b0;
		endcase
	end

	assign o_taken = i_val & exec_pkg::is_branch(i_uop) & cond;
	assign o_target = i_pc + i_imm;
	assign o_kill_now = o_taken ? ({{(exec_pkg::WIDTH_BRM-1){1'b0}}, 1'b1} << i_brtag) : '0;

	// keeps the kill alive for micro-ops still in read stage next cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			kill_prev <= '0;
		else
			kill_prev <= o_kill_now;
	end

	assign o_kill_mask = o_kill_now | kill_prev;

endmodule

// File: logic/exec_lane.sv
`timescale 1ns/100ps

module exec_lane #(
	parameter int HAS_BRANCH = 1
) (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_iss_val,
	input  exec_pkg::uop_e                   i_iss_uop,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prd,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs1,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs2,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_iss_imm,
	input  logic [exec_pkg::WIDTH_BRM-1:0]   i_iss_brmask,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_iss_pc,
	input  logic [exec_pkg::WIDTH_BRT-1:0]   i_iss_brtag,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op1,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_op2,
	input  logic [exec_pkg::WIDTH_BRM-1:0]   i_kill_mask,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_rr_prs1,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_rr_prs2,
	output logic                             o_ex_val,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_ex_prd,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_ex_data,
	output logic                             o_wb_val,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_wb_prd,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_wb_data,
	output logic [exec_pkg::WIDTH_BRM-1:0]   o_kill_mask,
	output logic                             o_redirect_val,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_redirect_pc,
	output logic [exec_pkg::WIDTH_BRM-1:0]   o_brkill
);

	// read stage
	logic                            rr_val;
	exec_pkg::uop_e                  rr_uop;
	logic [exec_pkg::WIDTH_PRD-1:0]  rr_prd;
	logic [exec_pkg::WIDTH_DATA-1:0] rr_imm;
	logic [exec_pkg::WIDTH_BRM-1:0]  rr_brmask;

	// execute stage
	logic                            ex_val;
	exec_pkg::uop_e                  ex_uop;
	logic [exec_pkg::WIDTH_DATA-1:0] ex_op1;
	logic [exec_pkg::WIDTH_DATA-1:0] ex_op2;
	logic [exec_pkg::WIDTH_DATA-1:0] ex_imm;
	logic [exec_pkg::WIDTH_BRM-1:0]  ex_brmask;
	logic                            ex_live;
	logic                            ex_wr;
	logic [exec_pkg::WIDTH_DATA-1:0] alu_result;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rr_val <= 1'b0;
			ex_val <= 1'b0;
			o_wb_val <= 1'b0;
		end else begin
			rr_val <= i_iss_val;
			// squashed read-stage ops never reach execute
			ex_val <= rr_val & ~exec_pkg::killed(rr_brmask, i_kill_mask);
			o_wb_val <= ex_wr;
		end
	end

	always_ff @(posedge i_clk) begin
		rr_uop <= i_iss_uop;
		rr_prd <= i_iss_prd;
		o_rr_prs1 <= i_iss_prs1;
		o_rr_prs2 <= i_iss_prs2;
		rr_imm <= i_iss_imm;
		rr_brmask <= i_iss_brmask;
		ex_uop <= rr_uop;
		o_ex_prd <= rr_prd;
		ex_op1 <= i_op1;
		ex_op2 <= i_op2;
		ex_imm <= rr_imm;
		ex_brmask <= rr_brmask;
		o_wb_prd <= o_ex_prd;
		o_wb_data <= alu_result;
	end

	int_alu u_alu (
		.i_uop    (ex_uop),
		.i_op1    (ex_op1),
		.i_op2    (ex_op2),
		.i_imm    (ex_imm),
		.o_result (alu_result)
	);

	assign ex_live = ex_val & ~exec_pkg::killed(ex_brmask, i_kill_mask);
	// branches have no destination
	assign ex_wr = ex_live & ~exec_pkg::is_branch(ex_uop);

	assign o_ex_val = ex_wr;
	assign o_ex_data = alu_result;

	generate
		if (HAS_BRANCH != 0) begin : g_branch
			logic [exec_pkg::WIDTH_DATA-1:0] rr_pc;
			logic [exec_pkg::WIDTH_BRT-1:0]  rr_brtag;
			logic [exec_pkg::WIDTH_DATA-1:0] ex_pc;
			logic [exec_pkg::WIDTH_BRT-1:0]  ex_brtag;
			logic                            taken;
			logic [exec_pkg::WIDTH_DATA-1:0] target;
			logic [exec_pkg::WIDTH_BRM-1:0]  kill_now;

			always_ff @(posedge i_clk) begin
				rr_pc <= i_iss_pc;
				rr_brtag <= i_iss_brtag;
				ex_pc <= rr_pc;
				ex_brtag <= rr_brtag;
				o_redirect_pc <= target;
			end

			// a branch in execute was not hit by its own older kill, so raw ex_val
			branch_unit u_branch (
				.i_clk       (i_clk),
				.i_rst_n     (i_rst_n),
				.i_val       (ex_val),
				.i_uop       (ex_uop),
				.i_op1       (ex_op1),
				.i_op2       (ex_op2),
				.i_pc        (ex_pc),
				.i_imm       (ex_imm),
				.i_brtag     (ex_brtag),
				.o_taken     (taken),
				.o_target    (target),
				.o_kill_now  (kill_now),
				.o_kill_mask (o_kill_mask)
			);

			always_ff @(posedge i_clk or negedge i_rst_n) begin
				if (!i_rst_n) begin
					o_redirect_val <= 1'b0;
					o_brkill <= '0;
				end else begin
					o_redirect_val <= taken;
					o_brkill <= kill_now;
				end
			end
		end else begin : g_no_branch
			assign o_kill_mask = '0;
			assign o_redirect_val = 1'b0;
			assign o_redirect_pc = '0;
			assign o_brkill = '0;

			// issue must steer branches to lane 0
			assert property (@(posedge i_clk) disable iff (!i_rst_n)
				i_iss_val |-> !exec_pkg::is_branch(i_iss_uop))
			else
				$error("exec_lane: branch issued to a lane without branch unit");
		end
	endgenerate

	// p0 is never allocated as a destination
	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_wb_val |-> (o_wb_prd != '0))
	else
		$error("exec_lane: writeback to p0");

endmodule

// File: logic/exec_backend.sv
`timescale 1ns/100ps

module exec_backend (
	input  logic                             i_clk,
	input  logic                             i_rst_n,

	// lane 0, alu and branch
	input  logic                             i_iss_val_0,
	input  exec_pkg::uop_e                   i_iss_uop_0,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prd_0,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs1_0,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs2_0,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_iss_imm_0,
	input  logic [exec_pkg::WIDTH_BRM-1:0]   i_iss_brmask_0,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_iss_pc_0,
	input  logic [exec_pkg::WIDTH_BRT-1:0]   i_iss_brtag_0,

	// lane 1, alu only
	input  logic                             i_iss_val_1,
	input  exec_pkg::uop_e                   i_iss_uop_1,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prd_1,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs1_1,
	input  logic [exec_pkg::WIDTH_PRD-1:0]   i_iss_prs2_1,
	input  logic [exec_pkg::WIDTH_DATA-1:0]  i_iss_imm_1,
	input  logic [exec_pkg::WIDTH_BRM-1:0]   i_iss_brmask_1,

	output logic                             o_wb_val_0,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_wb_prd_0,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_wb_data_0,
	output logic                             o_wb_val_1,
	output logic [exec_pkg::WIDTH_PRD-1:0]   o_wb_prd_1,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_wb_data_1,
	output logic                             o_redirect_val,
	output logic [exec_pkg::WIDTH_DATA-1:0]  o_redirect_pc,
	output logic [exec_pkg::WIDTH_BRM-1:0]   o_brkill
);

	// sources indexed {lane0 prs1, lane0 prs2, lane1 prs1, lane1 prs2}
	logic [exec_pkg::WIDTH_PRD-1:0]  rr_prs  [2*exec_pkg::NUM_LANES];
	logic [exec_pkg::WIDTH_DATA-1:0] rf_data [2*exec_pkg::NUM_LANES];
	logic [exec_pkg::WIDTH_DATA-1:0] op      [2*exec_pkg::NUM_LANES];

	logic                            ex_val  [exec_pkg::NUM_LANES];
	logic [exec_pkg::WIDTH_PRD-1:0]  ex_prd  [exec_pkg::NUM_LANES];
	logic [exec_pkg::WIDTH_DATA-1:0] ex_data [exec_pkg::NUM_LANES];

	// current plus previous cycle kill, from lane 0
	logic [exec_pkg::WIDTH_BRM-1:0]  kill_mask;

	exec_lane #(.HAS_BRANCH(1)) u_lane0 (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_iss_val      (i_iss_val_0),
		.i_iss_uop      (i_iss_uop_0),
		.i_iss_prd      (i_iss_prd_0),
		.i_iss_prs1     (i_iss_prs1_0),
		.i_iss_prs2     (i_iss_prs2_0),
		.i_iss_imm      (i_iss_imm_0),
		.i_iss_brmask   (i_iss_brmask_0),
		.i_iss_pc       (i_iss_pc_0),
		.i_iss_brtag    (i_iss_brtag_0),
		.i_op1          (op[0]),
		.i_op2          (op[1]),
		.i_kill_mask    (kill_mask),
		.o_rr_prs1      (rr_prs[0]),
		.o_rr_prs2      (rr_prs[1]),
		.o_ex_val       (ex_val[0]),
		.o_ex_prd       (ex_prd[0]),
		.o_ex_data      (ex_data[0]),
		.o_wb_val       (o_wb_val_0),
		.o_wb_prd       (o_wb_prd_0),
		.o_wb_data      (o_wb_data_0),
		.o_kill_mask    (kill_mask),
		.o_redirect_val (o_redirect_val),
		.o_redirect_pc  (o_redirect_pc),
		.o_brkill       (o_brkill)
	);

	exec_lane #(.HAS_BRANCH(0)) u_lane1 (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_iss_val      (i_iss_val_1),
		.i_iss_uop      (i_iss_uop_1),
		.i_iss_prd      (i_iss_prd_1),
		.i_iss_prs1     (i_iss_prs1_1),
		.i_iss_prs2     (i_iss_prs2_1),
		.i_iss_imm      (i_iss_imm_1),
		.i_iss_brmask   (i_iss_brmask_1),
		.i_iss_pc       ('0),
		.i_iss_brtag    ('0),
		.i_op1          (op[2]),
		.i_op2          (op[3]),
		.i_kill_mask    (kill_mask),
		.o_rr_prs1      (rr_prs[2]),
		.o_rr_prs2      (rr_prs[3]),
		.o_ex_val       (ex_val[1]),
		.o_ex_prd       (ex_prd[1]),
		.o_ex_data      (ex_data[1]),
		.o_wb_val       (o_wb_val_1),
		.o_wb_prd       (o_wb_prd_1),
		.o_wb_data      (o_wb_data_1),
		.o_kill_mask    (),
		.o_redirect_val (),
		.o_redirect_pc  (),
		.o_brkill       ()
	);

	prf_regfile u_prf (
		.i_clk   (i_clk),
		.i_raddr (rr_prs),
		.i_we    ('{o_wb_val_0, o_wb_val_1}),
		.i_waddr ('{o_wb_prd_0, o_wb_prd_1}),
		.i_wdata ('{o_wb_data_0, o_wb_data_1}),
		.o_rdata (rf_data)
	);

	operand_bypass u_bypass (
		.i_prs     (rr_prs),
		.i_rf_data (rf_data),
		.i_ex_val  (ex_val),
		.i_ex_prd  (ex_prd),
		.i_ex_data (ex_data),
		.i_wb_val  ('{o_wb_val_0, o_wb_val_1}),
		.i_wb_prd  ('{o_wb_prd_0, o_wb_prd_1}),
		.i_wb_data ('{o_wb_data_0, o_wb_data_1}),
		.o_op      (op)
	);

endmodule

// File: tb/exec_backend_tb.sv
`timescale 1ns/100ps

module exec_backend_tb;

	typedef struct {
		int                              due;
		// 0 and 1 are writeback lanes, 2 is the redirect port
		int                              lane;
		logic [exec_pkg::WIDTH_PRD-1:0]  prd;
		logic [exec_pkg::WIDTH_DATA-1:0] data;
		logic [exec_pkg::WIDTH_BRM-1:0]  kill;
	} exp_entry_t;

	logic                            i_clk;
	logic                            i_rst_n;
	logic                            iss_val    [2];
	exec_pkg::uop_e                  iss_uop    [2];
	logic [exec_pkg::WIDTH_PRD-1:0]  iss_prd    [2];
	logic [exec_pkg::WIDTH_PRD-1:0]  iss_prs1   [2];
	logic [exec_pkg::WIDTH_PRD-1:0]  iss_prs2   [2];
	logic [exec_pkg::WIDTH_DATA-1:0] iss_imm    [2];
	logic [exec_pkg::WIDTH_BRM-1:0]  iss_brmask [2];
	logic [exec_pkg::WIDTH_DATA-1:0] iss_pc;
	logic [exec_pkg::WIDTH_BRT-1:0]  iss_brtag;

	logic                            o_wb_val_0, o_wb_val_1, o_redirect_val;
	logic [exec_pkg::WIDTH_PRD-1:0]  o_wb_prd_0, o_wb_prd_1;
	logic [exec_pkg::WIDTH_DATA-1:0] o_wb_data_0, o_wb_data_1, o_redirect_pc;
	logic [exec_pkg::WIDTH_BRM-1:0]  o_brkill;

	// reference model state
	logic [exec_pkg::WIDTH_DATA-1:0] rf_model  [exec_pkg::NUM_PRD];
	logic                            pend_en   [2];
	logic [exec_pkg::WIDTH_PRD-1:0]  pend_prd  [2];
	logic [exec_pkg::WIDTH_DATA-1:0] pend_data [2];
	exp_entry_t                      expq      [$];
	integer                          seed = 32'h1624_7475;
	int                              edge_cnt = 0;
	int                              next_prd = 1;
	int                              br_edge = -100;
	int                              br_tag = 0;

	// expected outputs for the current cycle
	logic                            exp_wb_val  [2] = '{1'b0, 1'b0};
	logic [exec_pkg::WIDTH_PRD-1:0]  exp_wb_prd  [2] = '{'0, '0};
	logic [exec_pkg::WIDTH_DATA-1:0] exp_wb_data [2] = '{'0, '0};
	logic                            exp_redir_val = 1'b0;
	logic [exec_pkg::WIDTH_DATA-1:0] exp_redir_pc = '0;
	logic [exec_pkg::WIDTH_BRM-1:0]  exp_brkill = '0;

	exec_backend exec_backend_i (
		.i_clk (i_clk), .i_rst_n (i_rst_n),
		.i_iss_val_0 (iss_val[0]), .i_iss_uop_0 (iss_uop[0]), .i_iss_prd_0 (iss_prd[0]),
		.i_iss_prs1_0 (iss_prs1[0]), .i_iss_prs2_0 (iss_prs2[0]), .i_iss_imm_0 (iss_imm[0]),
		.i_iss_brmask_0 (iss_brmask[0]), .i_iss_pc_0 (iss_pc), .i_iss_brtag_0 (iss_brtag),
		.i_iss_val_1 (iss_val[1]), .i_iss_uop_1 (iss_uop[1]), .i_iss_prd_1 (iss_prd[1]),
		.i_iss_prs1_1 (iss_prs1[1]), .i_iss_prs2_1 (iss_prs2[1]), .i_iss_imm_1 (iss_imm[1]),
		.i_iss_brmask_1 (iss_brmask[1]),
		.o_wb_val_0 (o_wb_val_0), .o_wb_prd_0 (o_wb_prd_0), .o_wb_data_0 (o_wb_data_0),
		.o_wb_val_1 (o_wb_val_1), .o_wb_prd_1 (o_wb_prd_1), .o_wb_data_1 (o_wb_data_1),
		.o_redirect_val (o_redirect_val), .o_redirect_pc (o_redirect_pc), .o_brkill (o_brkill)
	);

	always #2 i_clk = ~i_clk;

	task automatic report_mismatch(string what);
		$display("ERR %0t: %s does not match the model", $time, what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] alu_ref(exec_pkg::uop_e uop, logic [31:0] a, logic [31:0] b,
			logic [31:0] imm);
		case (uop)
			exec_pkg::UOP_ADD:  return a + b;
			exec_pkg::UOP_SUB:  return a - b;
			exec_pkg::UOP_AND:  return a & b;
			exec_pkg::UOP_OR:   return a | b;
			exec_pkg::UOP_XOR:  return a ^ b;
			exec_pkg::UOP_SLL:  return a << b[4:0];
			exec_pkg::UOP_SRL:  return a >> b[4:0];
			exec_pkg::UOP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::UOP_ADDI: return a + imm;
			default:            return '0;
		endcase
	endfunction

	function automatic logic taken_ref(exec_pkg::uop_e uop, logic [31:0] a, logic [31:0] b);
		case (uop)
			exec_pkg::UOP_BEQ: return a == b;
			exec_pkg::UOP_BNE: return a != b;
			exec_pkg::UOP_BLT: return $signed(a) < $signed(b);
			exec_pkg::UOP_BGE: return $signed(a) >= $signed(b);
			default:           return 1'b0;
		endcase
	endfunction

	function automatic int alloc_prd();
		int p;
		p = next_prd;
		next_prd = (next_prd == exec_pkg::NUM_PRD - 1) ? 1 : next_prd + 1;
		return p;
	endfunction

	function automatic int rnd_reg();
		return 1 + ({$random(seed)} % (exec_pkg::NUM_PRD - 1));
	endfunction

	// p0 now and then
	function automatic int rnd_src();
		if ({$random(seed)} % 8 == 0)
			return 0;
		return rnd_reg();
	endfunction

	function automatic exec_pkg::uop_e rnd_uop();
		return exec_pkg::uop_e'({$random(seed)} % 9);
	endfunction

	// commit last cycle's results, then move to the next drive point
	task automatic step();
		for (int l = 0; l < 2; l++) begin
			if (pend_en[l])
				rf_model[pend_prd[l]] = pend_data[l];
			pend_en[l] = 1'b0;
		end
		@(posedge i_clk);
		#0.5;
		for (int l = 0; l < 2; l++) begin
			iss_val[l] = 1'b0;
			iss_brmask[l] = '0;
		end
	endtask

	task automatic put_alu(int lane, exec_pkg::uop_e uop, int prd, int prs1, int prs2,
			logic [31:0] imm, logic [7:0] brmask);
		int         e;
		exp_entry_t ent;
		e = edge_cnt + 1;
		iss_val[lane] = 1'b1;
		iss_uop[lane] = uop;
		iss_prd[lane] = prd;
		iss_prs1[lane] = prs1;
		iss_prs2[lane] = prs2;
		iss_imm[lane] = imm;
		iss_brmask[lane] = brmask;
		// squashed when issued with the branch or up to two cycles later
		if (brmask[br_tag] && e - br_edge >= 0 && e - br_edge <= 2)
			return;
		ent.due = e + 2;
		ent.lane = lane;
		ent.prd = prd;
		ent.data = alu_ref(uop, rf_model[prs1], rf_model[prs2], imm);
		ent.kill = '0;
		expq.push_back(ent);
		pend_en[lane] = 1'b1;
		pend_prd[lane] = prd;
		pend_data[lane] = ent.data;
	endtask

	task automatic put_branch(exec_pkg::uop_e uop, int prs1, int prs2, int tag);
		exp_entry_t ent;
		iss_val[0] = 1'b1;
		iss_uop[0] = uop;
		iss_prd[0] = '0;
		iss_prs1[0] = prs1;
		iss_prs2[0] = prs2;
		iss_imm[0] = $random(seed);
		iss_pc = $random(seed);
		iss_brtag = tag;
		if (taken_ref(uop, rf_model[prs1], rf_model[prs2])) begin
			br_edge = edge_cnt + 1;
			br_tag = tag;
			ent.due = br_edge + 2;
			ent.lane = 2;
			ent.prd = '0;
			ent.data = iss_pc + iss_imm[0];
			ent.kill = 8'd1 << tag;
			expq.push_back(ent);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (expq.size() > 0) begin
			if (waited > 10)
				report_timeout("the pending writebacks and redirects");
			step();
			waited++;
		end
		step();
	endtask

	always @(posedge i_clk) begin : model_outputs
		int         nxt;
		exp_entry_t ent;
		nxt = edge_cnt + 1;
		edge_cnt <= nxt;
		exp_wb_val[0] <= 1'b0;
		exp_wb_val[1] <= 1'b0;
		exp_redir_val <= 1'b0;
		exp_brkill <= '0;
		while (expq.size() > 0 && expq[0].due == nxt) begin
			ent = expq.pop_front();
			if (ent.lane == 2) begin
				exp_redir_val <= 1'b1;
				exp_redir_pc <= ent.data;
				exp_brkill <= ent.kill;
			end else begin
				exp_wb_val[ent.lane] <= 1'b1;
				exp_wb_prd[ent.lane] <= ent.prd;
				exp_wb_data[ent.lane] <= ent.data;
			end
		end
	end

	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_wb_val_0 == exp_wb_val[0])
	else report_mismatch("lane 0 writeback valid");
	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_wb_val_1 == exp_wb_val[1])
	else report_mismatch("lane 1 writeback valid");
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		exp_wb_val[0] |-> (o_wb_prd_0 == exp_wb_prd[0] && o_wb_data_0 == exp_wb_data[0]))
	else report_mismatch("lane 0 writeback register or data");
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		exp_wb_val[1] |-> (o_wb_prd_1 == exp_wb_prd[1] && o_wb_data_1 == exp_wb_data[1]))
	else report_mismatch("lane 1 writeback register or data");
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_redirect_val == exp_redir_val && o_brkill == exp_brkill)
	else report_mismatch("redirect valid or kill mask");
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		exp_redir_val |-> o_redirect_pc == exp_redir_pc)
	else report_mismatch("redirect pc");

	initial begin : stimulus
		int          h0 [3];
		int          h1 [3];
		int          a;
		int          b;
		logic [7:0]  hit;
		logic [7:0]  miss;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		for (int l = 0; l < 2; l++) begin
			iss_val[l] = 1'b0;
			iss_uop[l] = exec_pkg::UOP_ADD;
			iss_prd[l] = '0;
			iss_prs1[l] = '0;
			iss_prs2[l] = '0;
			iss_imm[l] = '0;
			iss_brmask[l] = '0;
			pend_en[l] = 1'b0;
		end
		iss_pc = '0;
		iss_brtag = '0;
		for (int r = 0; r < exec_pkg::NUM_PRD; r++)
			rf_model[r] = '0;
		repeat (8) @(posedge i_clk);
		#0.5;
		i_rst_n = 1'b1;

		// idle outputs stay quiet
		repeat (10) step();

		// fill p1..p127 from p0
		for (int r = 1; r < exec_pkg::NUM_PRD; r += 2) begin
			put_alu(0, exec_pkg::UOP_ADDI, alloc_prd(), 0, 0, $random(seed), '0);
			if (r + 1 < exec_pkg::NUM_PRD)
				put_alu(1, exec_pkg::UOP_ADDI, alloc_prd(), 0, 0, $random(seed), '0);
			step();
		end
		drain();

		for (int i = 0; i < 90; i++) begin
			put_alu(0, exec_pkg::uop_e'(i % 9), alloc_prd(), rnd_src(), rnd_src(),
				$random(seed), '0);
			put_alu(1, exec_pkg::uop_e'((i + 4) % 9), alloc_prd(), rnd_src(), rnd_src(),
				$random(seed), '0);
			step();
		end
		drain();

		// chains hit execute, writeback and regfile sources
		for (int i = 0; i < 3; i++) begin
			h0[i] = rnd_reg();
			h1[i] = rnd_reg();
		end
		for (int c = 0; c < 40; c++) begin
			a = alloc_prd();
			b = alloc_prd();
			put_alu(0, rnd_uop(), a, h0[0], h1[1], $random(seed), '0);
			put_alu(1, rnd_uop(), b, h0[0], h0[2], $random(seed), '0);
			h0[2] = h0[1];
			h0[1] = h0[0];
			h0[0] = a;
			h1[2] = h1[1];
			h1[1] = h1[0];
			h1[0] = b;
			step();
		end
		drain();

		for (int u = 0; u < 4; u++) begin
			for (int v = 0; v < 4; v++) begin
				a = rnd_reg();
				b = (v == 0) ? a : (v == 1) ? 0 : rnd_reg();
				put_branch(exec_pkg::uop_e'(int'(exec_pkg::UOP_BEQ) + u), a, b,
					{$random(seed)} % 8);
				put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), '0);
				step();
			end
		end
		drain();

		// masked micro-ops around a taken branch
		for (int t = 0; t < exec_pkg::WIDTH_BRM; t++) begin
			hit = $random(seed);
			hit[t] = 1'b1;
			miss = $random(seed);
			miss[t] = 1'b0;
			put_alu(0, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), miss);
			put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			step();
			put_branch((t % 2 == 0) ? exec_pkg::UOP_BEQ : exec_pkg::UOP_BGE, 0, 0, t);
			put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			step();
			put_alu(0, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), miss);
			step();
			put_alu(0, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), miss);
			put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			step();
			put_alu(0, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			put_alu(1, rnd_uop(), alloc_prd(), rnd_src(), rnd_src(), $random(seed), hit);
			repeat (3) step();
		end
		drain();

		$display("all tests passed");
		$finish;
	end

endmodule

// File: exec_backend.f
logic/exec_pkg.sv
logic/prf_regfile.sv
logic/operand_bypass.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/exec_lane.sv
logic/exec_backend.sv
tb/exec_backend_tb.sv

// File: Bender.yml
package:
  name: exec_backend

sources:
  - logic/exec_pkg.sv
  - logic/prf_regfile.sv
  - logic/operand_bypass.sv
  - logic/int_alu.sv
  - logic/branch_unit.sv
  - logic/exec_lane.sv
  - logic/exec_backend.sv
  - target: simulation
    files:
      - tb/exec_backend_tb.sv
